// ==== src/dma_pkg.sv ====
// widths, limits, word/address types, copy request and burst command structs
`default_nettype none

package dma_pkg;

  // ----------------------------------------------------------------------
  // widths and limits
  // ----------------------------------------------------------------------
  localparam int unsigned AddrWidth     = 32;
  localparam int unsigned DataWidth     = 32;
  // word aligned only, low two address bits stay zero
  localparam int unsigned WordBytes     = 4;
  localparam int unsigned LenWidth      = 16;
  // bus len field holds beats minus one
  localparam int unsigned BurstLenWidth = 4;
  localparam int unsigned MaxBurstBeats = 16;
  // no burst may cross this boundary
  localparam int unsigned PageBytes     = 4096;

  // buffer depths
  localparam int unsigned ReqFifoDepth  = 4;
  localparam int unsigned CmdFifoDepth  = 4;
  localparam int unsigned DataFifoDepth = 4;

  // ----------------------------------------------------------------------
  // types
  // ----------------------------------------------------------------------
  typedef logic [AddrWidth-1:0]     addr_t;
  typedef logic [DataWidth-1:0]     data_t;
  typedef logic [LenWidth-1:0]      len_t;
  typedef logic [BurstLenWidth-1:0] blen_t;

  // one 1D copy, length in words
  typedef struct packed {
    addr_t src;
    addr_t dst;
    len_t  num_words;
    logic  serialize;
  } copy_req_t;

  // one bus burst, last marks the final burst of a copy
  typedef struct packed {
    addr_t addr;
    blen_t len;
    logic  last;
  } burst_cmd_t;

endpackage

`default_nettype wire

// ==== src/dma_burst_if.sv ====
// burst command interface between splitter and data mover, with src/dst modports
`timescale 1ns/1ps
`default_nettype none

interface dma_burst_if;

  // handshake
  logic           valid;
  logic           ready;

  // payload, held stable while valid waits for ready
  dma_pkg::addr_t rd_addr;
  dma_pkg::addr_t wr_addr;
  // same len for read and write burst, both sides word aligned
  dma_pkg::blen_t len;
  // final burst of the copy
  logic           last;

  // splitter side
  modport src (output valid, rd_addr, wr_addr, len, last, input ready);

  // mover side
  modport dst (input valid, rd_addr, wr_addr, len, last, output ready);

endinterface

`default_nettype wire

// ==== src/dma_fifo.sv ====
// circular buffer FIFO with type parameter, head item output and full/empty flags
`timescale 1ns/1ps
`default_nettype none

module dma_fifo #(
  parameter type         item_t = logic,
  parameter int unsigned Depth  = 4
) (
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  input  wire logic  push_i,
  input  wire item_t item_i,
  input  wire logic  pop_i,
  output item_t      item_o,
  output logic       full_o,
  output logic       empty_o
);

  typedef logic [$clog2(Depth)-1:0]   ptr_t;
  typedef logic [$clog2(Depth+1)-1:0] cnt_t;

  // storage
  item_t mem_q [Depth];
  ptr_t  wr_ptr_q;
  ptr_t  rd_ptr_q;
  cnt_t  cnt_q;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= item_i;
    end
  end

  // pointers wrap at Depth, count tracks fill level
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + cnt_t'(push_i) - cnt_t'(pop_i);
    end
  end

  // head item always visible
  assign item_o  = mem_q[rd_ptr_q];
  assign full_o  = (cnt_q == cnt_t'(Depth));
  assign empty_o = (cnt_q == '0);

  // the user must respect the flags
  a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o);
  a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o);

endmodule

`default_nettype wire

// ==== src/dma_req_queue.sv ====
// request FIFO with serialize gating, in-flight tracking and zero-length discard
`timescale 1ns/1ps
`default_nettype none

module dma_req_queue (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire dma_pkg::copy_req_t req_i,
  input  wire logic               valid_i,
  output logic                    ready_o,
  output dma_pkg::copy_req_t      req_o,
  output logic                    req_valid_o,
  input  wire logic               req_ready_i,
  input  wire logic               trans_done_i,
  output logic                    busy_o
);

  // at most one copy in the splitter plus one per b command entry
  typedef logic [$clog2(dma_pkg::CmdFifoDepth + 2)-1:0] cnt_t;

  dma_pkg::copy_req_t head;
  logic               fifo_full;
  logic               fifo_empty;
  logic               fifo_pop;
  logic               head_zero;
  logic               head_gate;
  logic               hand_off;
  cnt_t               in_flight_q;

  dma_fifo #(
    .item_t(dma_pkg::copy_req_t),
    .Depth (dma_pkg::ReqFifoDepth)
  ) i_req_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (valid_i && ready_o),
    .item_i (req_i),
    .pop_i  (fifo_pop),
    .item_o (head),
    .full_o (fifo_full),
    .empty_o(fifo_empty)
  );

  assign ready_o = !fifo_full;

  // ----------------------------------------------------------------------
  // head gating
  // ----------------------------------------------------------------------
  assign head_zero = (head.num_words == '0);
  // serialized copy waits for an empty pipe, retiring copy counts as gone
  assign head_gate = !head.serialize || (in_flight_q == '0) ||
                     ((in_flight_q == cnt_t'(1)) && trans_done_i);

  assign req_o       = head;
  assign req_valid_o = !fifo_empty && !head_zero && head_gate;
  assign hand_off    = req_valid_o && req_ready_i;
  // zero length heads are dropped without hand-off
  assign fifo_pop    = hand_off || (!fifo_empty && head_zero);

  // copies between hand-off and completion
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_flight_q <= '0;
    end else begin
      in_flight_q <= in_flight_q + cnt_t'(hand_off) - cnt_t'(trans_done_i);
    end
  end

  assign busy_o = !fifo_empty || (in_flight_q != '0);

  // completion only ever retires a copy that was handed off
  a_done_has_owner : assert property (@(posedge clk_i) disable iff (!rst_ni)
    trans_done_i |-> (in_flight_q != '0));

endmodule

`default_nettype wire

// ==== src/dma_burst_splitter.sv ====
// burst splitter: cuts copy requests into bursts of at most 16 beats within a page
`timescale 1ns/1ps
`default_nettype none

module dma_burst_splitter (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire dma_pkg::copy_req_t req_i,
  input  wire logic               req_valid_i,
  output logic                    req_ready_o,
  dma_burst_if.src                burst,
  output logic                    busy_o
);

  // current copy
  logic           active_q;
  dma_pkg::addr_t src_q;
  dma_pkg::addr_t dst_q;
  dma_pkg::len_t  rem_q;

  // next burst
  dma_pkg::addr_t src_room;
  dma_pkg::addr_t dst_room;
  dma_pkg::addr_t beats_w;
  dma_pkg::addr_t step;
  dma_pkg::len_t  beats;
  logic           req_hs;
  logic           burst_hs;
  logic           last_burst;

  // ----------------------------------------------------------------------
  // burst size
  // ----------------------------------------------------------------------
  // words left before the next page boundary
  assign src_room = (dma_pkg::addr_t'(dma_pkg::PageBytes) -
                     (src_q & dma_pkg::addr_t'(dma_pkg::PageBytes - 1))) /
                    dma_pkg::addr_t'(dma_pkg::WordBytes);
  assign dst_room = (dma_pkg::addr_t'(dma_pkg::PageBytes) -
                     (dst_q & dma_pkg::addr_t'(dma_pkg::PageBytes - 1))) /
                    dma_pkg::addr_t'(dma_pkg::WordBytes);

  // least of remaining, max burst and both page limits
  always_comb begin
    beats_w = dma_pkg::addr_t'(dma_pkg::MaxBurstBeats);
    if (dma_pkg::addr_t'(rem_q) < beats_w) begin
      beats_w = dma_pkg::addr_t'(rem_q);
    end
    if (src_room < beats_w) begin
      beats_w = src_room;
    end
    if (dst_room < beats_w) begin
      beats_w = dst_room;
    end
  end

  assign beats      = dma_pkg::len_t'(beats_w);
  assign step       = beats_w * dma_pkg::addr_t'(dma_pkg::WordBytes);
  assign last_burst = (rem_q == beats);

  // ----------------------------------------------------------------------
  // burst output
  // ----------------------------------------------------------------------
  assign burst.valid   = active_q;
  assign burst.rd_addr = src_q;
  assign burst.wr_addr = dst_q;
  assign burst.len     = dma_pkg::blen_t'(beats - dma_pkg::len_t'(1));
  assign burst.last    = last_burst;

  assign burst_hs    = burst.valid && burst.ready;
  // new copy only once the current one is fully cut
  assign req_ready_o = !active_q;
  assign req_hs      = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
    end else if (req_hs) begin
      active_q <= 1'b1;
    end else if (burst_hs && last_burst) begin
      active_q <= 1'b0;
    end
  end

  // addresses and remainder advance per burst
  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      src_q <= req_i.src;
      dst_q <= req_i.dst;
      rem_q <= req_i.num_words;
    end else if (burst_hs) begin
      src_q <= src_q + step;
      dst_q <= dst_q + step;
      rem_q <= rem_q - beats;
    end
  end

  assign busy_o = active_q;

endmodule

`default_nettype wire

// ==== src/dma_data_mover.sv ====
// data mover: ar/aw issue, r to w data buffering, w beat count, b completion
`timescale 1ns/1ps
`default_nettype none

module dma_data_mover (
  input  wire logic           clk_i,
  input  wire logic           rst_ni,
  dma_burst_if.dst            burst,
  output logic                ar_valid_o,
  input  wire logic           ar_ready_i,
  output dma_pkg::addr_t      ar_addr_o,
  output dma_pkg::blen_t      ar_len_o,
  input  wire logic           r_valid_i,
  output logic                r_ready_o,
  input  wire dma_pkg::data_t r_data_i,
  input  wire logic           r_last_i,
  output logic                aw_valid_o,
  input  wire logic           aw_ready_i,
  output dma_pkg::addr_t      aw_addr_o,
  output dma_pkg::blen_t      aw_len_o,
  output logic                w_valid_o,
  input  wire logic           w_ready_i,
  output dma_pkg::data_t      w_data_o,
  output logic                w_last_o,
  input  wire logic           b_valid_i,
  output logic                b_ready_o,
  output logic                trans_done_o,
  output logic                busy_o
);

  // command slots: 0 ar, 1 aw, 2 w beat count, 3 b last flag
  dma_pkg::burst_cmd_t cmd_rd;
  dma_pkg::burst_cmd_t cmd_wr;
  dma_pkg::burst_cmd_t cmd_head [4];
  logic [3:0]          cmd_pop;
  logic [3:0]          cmd_full;
  logic [3:0]          cmd_empty;
  logic                cmd_push;

  logic                data_full;
  logic                data_empty;
  logic                ar_issued_q;
  dma_pkg::blen_t      r_cnt_q;
  dma_pkg::blen_t      w_cnt_q;
  logic                trans_done_q;
  logic                r_hs;
  logic                r_final;
  logic                w_hs;

  // ----------------------------------------------------------------------
  // command FIFOs
  // ----------------------------------------------------------------------
  assign cmd_rd = '{addr: burst.rd_addr, len: burst.len, last: burst.last};
  assign cmd_wr = '{addr: burst.wr_addr, len: burst.len, last: burst.last};
  // every burst goes into all four at once
  assign burst.ready = !(|cmd_full);
  assign cmd_push    = burst.valid && burst.ready;

  for (genvar g = 0; g < 4; g++) begin : gen_cmd_fifo
    dma_fifo #(
      .item_t(dma_pkg::burst_cmd_t),
      .Depth (dma_pkg::CmdFifoDepth)
    ) i_cmd_fifo (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .push_i (cmd_push),
      .item_i ((g == 0) ? cmd_rd : cmd_wr),
      .pop_i  (cmd_pop[g]),
      .item_o (cmd_head[g]),
      .full_o (cmd_full[g]),
      .empty_o(cmd_empty[g])
    );
  end

  // ----------------------------------------------------------------------
  // read side
  // ----------------------------------------------------------------------
  // ar head stays until its last r beat, one read burst outstanding
  assign ar_valid_o = !cmd_empty[0] && !ar_issued_q;
  assign ar_addr_o  = cmd_head[0].addr;
  assign ar_len_o   = cmd_head[0].len;

  assign r_ready_o  = !data_full;
  assign r_hs       = r_valid_i && r_ready_o;
  assign r_final    = (r_cnt_q == cmd_head[0].len);
  assign cmd_pop[0] = r_hs && r_final;

  dma_fifo #(
    .item_t(dma_pkg::data_t),
    .Depth (dma_pkg::DataFifoDepth)
  ) i_data_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (r_hs),
    .item_i (r_data_i),
    .pop_i  (w_hs),
    .item_o (w_data_o),
    .full_o (data_full),
    .empty_o(data_empty)
  );

  // ----------------------------------------------------------------------
  // write side
  // ----------------------------------------------------------------------
  assign aw_valid_o = !cmd_empty[1];
  assign aw_addr_o  = cmd_head[1].addr;
  assign aw_len_o   = cmd_head[1].len;
  assign cmd_pop[1] = aw_valid_o && aw_ready_i;

  // w beats counted against the head w command
  assign w_valid_o  = !data_empty && !cmd_empty[2];
  assign w_last_o   = (w_cnt_q == cmd_head[2].len);
  assign w_hs       = w_valid_o && w_ready_i;
  assign cmd_pop[2] = w_hs && w_last_o;

  // one b per burst, always accepted
  assign b_ready_o  = 1'b1;
  assign cmd_pop[3] = b_valid_i && b_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ar_issued_q  <= 1'b0;
      r_cnt_q      <= '0;
      w_cnt_q      <= '0;
      trans_done_q <= 1'b0;
    end else begin
      if (ar_valid_o && ar_ready_i) begin
        ar_issued_q <= 1'b1;
      end else if (cmd_pop[0]) begin
        ar_issued_q <= 1'b0;
      end
      if (r_hs) begin
        r_cnt_q <= r_final ? '0 : r_cnt_q + 1'b1;
      end
      if (w_hs) begin
        w_cnt_q <= w_last_o ? '0 : w_cnt_q + 1'b1;
      end
      // pulse the cycle after the b of the final burst
      trans_done_q <= cmd_pop[3] && cmd_head[3].last;
    end
  end

  assign trans_done_o = trans_done_q;
  assign busy_o       = !(&cmd_empty) || !data_empty;

  // memory must close each read burst on the requested beat
  a_r_last_match : assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_hs |-> (r_last_i == r_final));

endmodule

`default_nettype wire

// ==== src/dma_backend.sv ====
// DMA copy backend top: request packing, queue, splitter, data mover, idle flag
`timescale 1ns/1ps
`default_nettype none

module dma_backend (
  input  wire logic           clk_i,
  input  wire logic           rst_ni,
  // copy request
  input  wire dma_pkg::addr_t src_i,
  input  wire dma_pkg::addr_t dst_i,
  input  wire dma_pkg::len_t  num_words_i,
  input  wire logic           serialize_i,
  input  wire logic           valid_i,
  output logic                ready_o,
  // status
  output logic                idle_o,
  output logic                trans_complete_o,
  // burst memory bus
  output logic                ar_valid_o,
  input  wire logic           ar_ready_i,
  output dma_pkg::addr_t      ar_addr_o,
  output dma_pkg::blen_t      ar_len_o,
  input  wire logic           r_valid_i,
  output logic                r_ready_o,
  input  wire dma_pkg::data_t r_data_i,
  input  wire logic           r_last_i,
  output logic                aw_valid_o,
  input  wire logic           aw_ready_i,
  output dma_pkg::addr_t      aw_addr_o,
  output dma_pkg::blen_t      aw_len_o,
  output logic                w_valid_o,
  input  wire logic           w_ready_i,
  output dma_pkg::data_t      w_data_o,
  output logic                w_last_o,
  input  wire logic           b_valid_i,
  output logic                b_ready_o
);

  dma_pkg::copy_req_t req_in;
  dma_pkg::copy_req_t req_split;
  logic               req_valid;
  logic               req_ready;
  logic               trans_done;
  logic               queue_busy;
  logic               split_busy;
  logic               mover_busy;

  dma_burst_if burst_if ();

  assign req_in = '{src: src_i, dst: dst_i, num_words: num_words_i, serialize: serialize_i};

  //----------------------------------------------------------------------
  // input side
  //----------------------------------------------------------------------
  dma_req_queue i_req_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_in),
    .valid_i     (valid_i),
    .ready_o     (ready_o),
    .req_o       (req_split),
    .req_valid_o (req_valid),
    .req_ready_i (req_ready),
    .trans_done_i(trans_done),
    .busy_o      (queue_busy)
  );

  dma_burst_splitter i_burst_splitter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_split),
    .req_valid_i(req_valid),
    .req_ready_o(req_ready),
    .burst      (burst_if),
    .busy_o     (split_busy)
  );

  //----------------------------------------------------------------------
  // output side
  //----------------------------------------------------------------------
  dma_data_mover i_data_mover (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .burst       (burst_if),
    .ar_valid_o  (ar_valid_o),
    .ar_ready_i  (ar_ready_i),
    .ar_addr_o   (ar_addr_o),
    .ar_len_o    (ar_len_o),
    .r_valid_i   (r_valid_i),
    .r_ready_o   (r_ready_o),
    .r_data_i    (r_data_i),
    .r_last_i    (r_last_i),
    .aw_valid_o  (aw_valid_o),
    .aw_ready_i  (aw_ready_i),
    .aw_addr_o   (aw_addr_o),
    .aw_len_o    (aw_len_o),
    .w_valid_o   (w_valid_o),
    .w_ready_i   (w_ready_i),
    .w_data_o    (w_data_o),
    .w_last_o    (w_last_o),
    .b_valid_i   (b_valid_i),
    .b_ready_o   (b_ready_o),
    .trans_done_o(trans_done),
    .busy_o      (mover_busy)
  );

  // completion goes back to the queue and out
  assign trans_complete_o = trans_done;
  assign idle_o           = !(queue_busy || split_busy || mover_busy);

endmodule

`default_nettype wire

// ==== verif/tb_dma_backend.sv ====
// DMA copy backend testbench with burst memory model, pattern stimulus and checks
`timescale 1ns/1ps
`default_nettype none

module tb_dma_backend;

  localparam int unsigned MemWords      = 16384;
  localparam int unsigned MaxTransfers  = 32;
  localparam int          TimeoutCycles = 5000;

  typedef struct packed {
    dma_pkg::addr_t addr;
    dma_pkg::blen_t len;
    logic [15:0]    idx;
  } burst_t;

  // DUT ports
  logic           clk_i, rst_ni, serialize_i, valid_i, ready_o, idle_o, trans_complete_o;
  dma_pkg::addr_t src_i, dst_i, ar_addr_o, aw_addr_o;
  dma_pkg::len_t  num_words_i;
  dma_pkg::blen_t ar_len_o, aw_len_o;
  dma_pkg::data_t r_data_i, w_data_o;
  logic           ar_valid_o, ar_ready_i, r_valid_i, r_ready_o, r_last_i;
  logic           aw_valid_o, aw_ready_i, w_valid_o, w_ready_i, w_last_o;
  logic           b_valid_i, b_ready_o;

  // memory model and scoreboard state
  logic [31:0] mem [MemWords];
  logic [31:0] exp_mem [MemWords];
  logic [31:0] pat [MaxTransfers*6];
  logic [31:0] tr_src [MaxTransfers];
  logic [31:0] tr_dst [MaxTransfers];
  logic [31:0] tr_len [MaxTransfers];
  logic [31:0] tr_ser [MaxTransfers];
  logic [31:0] tr_stall [MaxTransfers];
  logic [31:0] tr_bursts [MaxTransfers];
  int          ar_seen [MaxTransfers];
  int          aw_seen [MaxTransfers];
  int          nz_before [MaxTransfers];
  int          nz_list [$];
  burst_t      exp_ar [$];
  burst_t      exp_aw [$];
  burst_t      rd_q [$];
  burst_t      wr_q [$];
  int          r_beat, w_beat, b_pend, done_cnt, num_tr;
  logic        hold_ar;
  logic [31:0] rng_q;

  dma_backend dut0 (.*);

  always #50 clk_i = ~clk_i;

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_q;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_q = x;
    return x;
  endfunction

  // source content hashed from the full byte address
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return (a * 32'h9e37_79b9) ^ 32'ha5a5_5a5a;
  endfunction

  function automatic logic [13:0] word_idx(input logic [31:0] a);
    return a[15:2];
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("Error: time %0t: %s, got %h expected %h", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("Timeout at %0t: %s", $time, why);
    $display("Test failures found");
    $fatal(1, "stopped after timeout");
  endtask

  // expected bursts take the least of remaining, 16 beats and room to both page ends
  task automatic add_bursts(input int k);
    logic [31:0] s, d, rem, beats, room;
    int          n;
    s   = tr_src[k];
    d   = tr_dst[k];
    rem = tr_len[k];
    n   = 0;
    while (rem != 0) begin
      beats = (rem > dma_pkg::MaxBurstBeats) ? dma_pkg::MaxBurstBeats : rem;
      room  = (dma_pkg::PageBytes - (s % dma_pkg::PageBytes)) / dma_pkg::WordBytes;
      beats = (room < beats) ? room : beats;
      room  = (dma_pkg::PageBytes - (d % dma_pkg::PageBytes)) / dma_pkg::WordBytes;
      beats = (room < beats) ? room : beats;
      exp_ar.push_back(burst_t'{addr: s, len: dma_pkg::blen_t'(beats - 1), idx: 16'(k)});
      exp_aw.push_back(burst_t'{addr: d, len: dma_pkg::blen_t'(beats - 1), idx: 16'(k)});
      s   = s + (beats << 2);
      d   = d + (beats << 2);
      rem = rem - beats;
      n++;
    end
    check(32'(n), tr_bursts[k], "burst count of pattern line");
  endtask

  // ----------------------------------------------------------------------
  // memory model driven on the falling edge and sampled before the rising one
  // ----------------------------------------------------------------------
  task automatic drive_bus();
    logic [31:0] rnd;
    rnd        = next_random();
    ar_ready_i = !hold_ar && (rnd[1:0] != 2'b00);
    aw_ready_i = (rnd[3:2] != 2'b00);
    // write data waits for its address burst
    w_ready_i  = (wr_q.size() != 0) && (rnd[5:4] != 2'b00);
    r_valid_i  = (rd_q.size() != 0) && (rnd[7:6] != 2'b00);
    b_valid_i  = (b_pend != 0) && (rnd[9:8] != 2'b00);
    r_data_i   = '0;
    r_last_i   = 1'b0;
    if (r_valid_i) begin
      r_data_i = mem[word_idx(rd_q[0].addr + 32'(r_beat * 4))];
      r_last_i = (r_beat == int'(rd_q[0].len));
    end
  endtask

  task automatic observe_bus();
    burst_t      b;
    int          k;
    logic [31:0] i;
    if (ar_valid_o && ar_ready_i) begin
      check(32'(exp_ar.size() != 0), 1, "ar burst without pending copy");
      b = exp_ar.pop_front();
      check(ar_addr_o, b.addr, "ar address");
      check(32'(ar_len_o), 32'(b.len), "ar len");
      // serialized copy starts after every earlier copy completed
      if (tr_ser[b.idx] != 0) begin
        check(32'(done_cnt >= nz_before[b.idx]), 1, "serialized ar before completion");
      end
      ar_seen[b.idx]++;
      rd_q.push_back(b);
    end
    if (r_valid_i && r_ready_o) begin
      if (r_last_i) begin
        rd_q.delete(0);
        r_beat = 0;
      end else begin
        r_beat++;
      end
    end
    if (aw_valid_o && aw_ready_i) begin
      check(32'(exp_aw.size() != 0), 1, "aw burst without pending copy");
      b = exp_aw.pop_front();
      check(aw_addr_o, b.addr, "aw address");
      check(32'(aw_len_o), 32'(b.len), "aw len");
      aw_seen[b.idx]++;
      wr_q.push_back(b);
    end
    if (w_valid_o && w_ready_i) begin
      mem[word_idx(wr_q[0].addr + 32'(w_beat * 4))] = w_data_o;
      check(32'(w_last_o), 32'(w_beat == int'(wr_q[0].len)), "w_last position");
      if (w_last_o) begin
        wr_q.delete(0);
        w_beat = 0;
        b_pend++;
      end else begin
        w_beat++;
      end
    end
    if (b_valid_i && b_ready_o) begin
      b_pend--;
    end
    // completions come in request order and never for zero length copies
    if (trans_complete_o) begin
      check(32'(done_cnt < nz_list.size()), 1, "completion pulse without copy");
      k = nz_list[done_cnt];
      check(32'(ar_seen[k]), tr_bursts[k], "read bursts of completed copy");
      check(32'(aw_seen[k]), tr_bursts[k], "write bursts of completed copy");
      for (i = 0; i < tr_len[k]; i++) begin
        check(mem[word_idx(tr_dst[k] + (i << 2))], fill_word(tr_src[k] + (i << 2)),
              "copied word");
        exp_mem[word_idx(tr_dst[k] + (i << 2))] = fill_word(tr_src[k] + (i << 2));
      end
      done_cnt++;
    end
  endtask

  initial begin
    rng_q      = 32'hd4e9b23d;
    r_beat     = 0;
    w_beat     = 0;
    b_pend     = 0;
    done_cnt   = 0;
    ar_ready_i = 1'b0;
    aw_ready_i = 1'b0;
    w_ready_i  = 1'b0;
    r_valid_i  = 1'b0;
    r_data_i   = '0;
    r_last_i   = 1'b0;
    b_valid_i  = 1'b0;
    for (int a = 0; a < MemWords; a++) begin
      mem[a]     = fill_word(32'(a) << 2);
      exp_mem[a] = mem[a];
    end
    forever begin
      @(negedge clk_i);
      drive_bus();
      #20;
      observe_bus();
    end
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  task automatic wait_idle();
    int waited;
    waited = 0;
    @(negedge clk_i);
    #20;
    while (!idle_o && waited < TimeoutCycles) begin
      @(negedge clk_i);
      #20;
      waited++;
    end
    if (!idle_o) abort_run("DUT did not return to idle");
  endtask

  task automatic push_req(input int k);
    int waited;
    add_bursts(k);
    nz_before[k] = nz_list.size();
    if (tr_len[k] != 0) nz_list.push_back(k);
    @(negedge clk_i);
    src_i       = tr_src[k];
    dst_i       = tr_dst[k];
    num_words_i = tr_len[k][15:0];
    serialize_i = tr_ser[k][0];
    valid_i     = 1'b1;
    waited      = 0;
    #20;
    while (!ready_o && waited < TimeoutCycles) begin
      @(negedge clk_i);
      #20;
      waited++;
    end
    if (!ready_o) abort_run("copy request was never accepted");
    // taken at the coming rising edge
    @(negedge clk_i);
    valid_i = 1'b0;
  endtask

  initial begin
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    src_i       = '0;
    dst_i       = '0;
    num_words_i = '0;
    serialize_i = 1'b0;
    valid_i     = 1'b0;
    hold_ar     = 1'b0;
    num_tr      = 0;
    for (int a = 0; a < MaxTransfers * 6; a++) pat[a] = '1;
    $readmemh("verif/dma_transfers_patterns.txt", pat);
    while (num_tr < MaxTransfers && pat[num_tr*6] != '1) begin
      tr_src[num_tr]    = pat[num_tr*6];
      tr_dst[num_tr]    = pat[num_tr*6+1];
      tr_len[num_tr]    = pat[num_tr*6+2];
      tr_ser[num_tr]    = pat[num_tr*6+3];
      tr_stall[num_tr]  = pat[num_tr*6+4];
      tr_bursts[num_tr] = pat[num_tr*6+5];
      ar_seen[num_tr]   = 0;
      aw_seen[num_tr]   = 0;
      num_tr++;
    end
    check(32'(num_tr > 0), 1, "copies read from pattern file");
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    #20;
    check(32'(idle_o), 1, "idle_o after reset");
    check(32'(ready_o), 1, "ready_o after reset");
    check(32'({ar_valid_o, aw_valid_o, w_valid_o, trans_complete_o}), 0, "valids after reset");
    for (int k = 0; k < num_tr; k++) begin
      // a stall group starts from an idle DUT so the splitter holds its first copy
      if (tr_stall[k] != 0 && !hold_ar) begin
        wait_idle();
        hold_ar = 1'b1;
      end
      push_req(k);
      if (tr_len[k] == 0) wait_idle();
      if (hold_ar && (k == num_tr - 1 || tr_stall[k+1] == 0)) begin
        repeat (4) @(negedge clk_i);
        #20;
        check(32'(ready_o), 0, "ready_o while ar is stalled");
        hold_ar = 1'b0;
      end
    end
    wait_idle();
    check(32'(done_cnt), 32'(nz_list.size()), "number of completion pulses");
    check(32'(exp_ar.size() + exp_aw.size()), 0, "bursts never issued");
    for (int a = 0; a < MemWords; a++) begin
      check(mem[a], exp_mem[a], "memory word after all copies");
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
src/dma_pkg.sv
src/dma_burst_if.sv
src/dma_fifo.sv
src/dma_req_queue.sv
src/dma_burst_splitter.sv
src/dma_data_mover.sv
src/dma_backend.sv
verif/tb_dma_backend.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the DMA backend testbench with Verilator, run it, decide on the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_dma_backend -f src.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || echo "build or simulation did not finish cleanly"
cat sim.log 2>/dev/null
grep -q "All tests passed!" sim.log 2>/dev/null \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

// ==== verif/dma_transfers_patterns.txt ====
// columns in hex: src dst num_words serialize stall bursts, one copy per line
// stall lines are pushed while ar_ready is held low, ready_o must drop after them
00000100 00008000 0008 0 0 1
00000200 00008100 0010 0 0 1
00000400 00008200 0028 0 0 3
00000FF0 00008400 000A 0 0 2
00001100 00008FE8 0014 1 0 2
00001200 00009100 0000 0 0 0
00001FF8 00009FF4 0015 1 0 4
00002100 0000A100 0020 1 0 2
00002200 0000A200 0005 0 0 1
00003000 0000B000 0064 0 1 7
00003200 0000B200 0064 0 1 7
00003400 0000B400 0064 0 1 7
00003600 0000B600 0064 0 1 7
00003800 0000B800 0064 0 1 7
00004F80 0000C000 0040 0 0 4
